/* common/mm_defs.svh */
//==========================================================================
// elements are signed integers and all sums wrap modulo 2^MM_ACC_W
// MM_ACC_W must be at least twice MM_ELEM_W to hold a full product
//==========================================================================
`ifndef MM_DEFS_SVH
`define MM_DEFS_SVH

// matrix dimension
// also the number of A/B beats in one job and of C rows out
`define MM_DIM 4

// width of one input element of A or B
`define MM_ELEM_W 16

// width of one accumulator cell and one C element
`define MM_ACC_W 32

`endif

/* common/mm_pkg.sv */
//==========================================================================
// shared types of the matrix multiplier, sized from mm_defs.svh
//==========================================================================
`default_nettype none

`include "mm_defs.svh"

package mm_pkg;

  // one signed element of A or B
  typedef logic signed [`MM_ELEM_W-1:0] elem_t;

  // one signed accumulator cell, also one element of C
  typedef logic signed [`MM_ACC_W-1:0] acc_t;

  // one A column or one B row, element k in slot k
  typedef elem_t [`MM_DIM-1:0] vec_t;

  // one C row as it leaves the kernel
  typedef acc_t [`MM_DIM-1:0] c_row_t;

  // A column k paired with B row k
  typedef struct packed {
    vec_t a_col;
    vec_t b_row;
  } operand_t;

  // the whole accumulator array, indexed [row][col]
  typedef c_row_t [`MM_DIM-1:0] matrix_t;

endpackage : mm_pkg

`default_nettype wire

/* common/mm_stream_if.sv */
//==========================================================================
// valid/ready stream; a beat moves on an edge with valid and ready high
// valid, last and data hold steady from the raise of valid to the transfer
//==========================================================================
`default_nettype none

interface mm_stream_if #(
  parameter type payload_t = logic
);

  // handshake
  logic     valid;
  logic     ready;
  // marks the final beat of a job
  logic     last;
  // payload, operand pair or C row
  payload_t data;

  // producer side
  modport src (
    output valid,
    output last,
    output data,
    input  ready
  );

  // consumer side
  modport snk (
    input  valid,
    input  last,
    input  data,
    output ready
  );

endinterface : mm_stream_if

`default_nettype wire

/* verilog/mm_ctrl.sv */
//==========================================================================
// start is taken on its rising edge while idle; a start while busy is lost
// done pulses one cycle after the final C transfer as idle goes high again
//==========================================================================
`default_nettype none

module mm_ctrl (
  input  wire  ap_clk,
  input  wire  areset,
  input  wire  i_start,
  input  wire  i_job_end,
  output logic o_busy,
  output logic o_idle,
  output logic o_done
);

  logic start_r;
  logic start_pulse;

  //========================================================================
  // start edge detection
  //========================================================================

  // previous value of start
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      start_r <= 1'b0;
    end else begin
      start_r <= i_start;
    end
  end

  // high for one cycle when start goes from 0 to 1
  assign start_pulse = i_start & ~start_r;

  //========================================================================
  // busy level and done pulse
  //========================================================================

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      o_busy <= 1'b0;
      o_done <= 1'b0;
    end else begin
      // done follows the last C row by one edge
      o_done <= i_job_end & o_busy;
      // job end wins over a start in the same cycle
      if (i_job_end) begin
        o_busy <= 1'b0;
      end else if (start_pulse) begin
        o_busy <= 1'b1;
      end
    end
  end

  assign o_idle = ~o_busy;

  // the final C row only leaves while a job runs
  a_end_in_job : assert property (@(posedge ap_clk) disable iff (areset)
    i_job_end |-> o_busy);

endmodule : mm_ctrl

`default_nettype wire

/* verilog/operand_join.sv */
//==========================================================================
// A and B are accepted only together and only while a job runs
// the MM_DIM-th pair of a job is marked last; extra beats start a new count
//==========================================================================
`default_nettype none

`include "mm_defs.svh"

module operand_join (
  input  wire          ap_clk,
  input  wire          areset,
  input  wire          i_busy,
  // A stream carrying one column per beat
  input  wire          i_a_valid,
  output logic         o_a_ready,
  input  mm_pkg::vec_t i_a_data,
  // B stream carrying one row per beat
  input  wire          i_b_valid,
  output logic         o_b_ready,
  input  mm_pkg::vec_t i_b_data,
  // paired operands towards the MAC array
  mm_stream_if.src     o_op
);

  localparam int CNT_W = (`MM_DIM > 1) ? $clog2(`MM_DIM) : 1;

  logic [CNT_W-1:0] beat_cnt;
  logic             pair_valid;
  logic             pair_fire;
  logic             last_beat;

  // a pair exists when both inputs offer a beat during a job
  assign pair_valid = i_busy & i_a_valid & i_b_valid;
  assign pair_fire  = pair_valid & o_op.ready;

  // both sides move on the same edge
  assign o_a_ready = pair_fire;
  assign o_b_ready = pair_fire;

  assign last_beat = (beat_cnt == CNT_W'(`MM_DIM - 1));

  // zero latency join
  assign o_op.valid = pair_valid;
  assign o_op.last  = last_beat;
  assign o_op.data  = mm_pkg::operand_t'{a_col: i_a_data, b_row: i_b_data};

  // beat count within the job
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      beat_cnt <= '0;
    end else if (pair_fire) begin
      if (last_beat) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // a finished job leaves no partial beat count behind
  a_cnt_clear_idle : assert property (@(posedge ap_clk) disable iff (areset)
    !i_busy |-> (beat_cnt == '0));

endmodule : operand_join

`default_nettype wire

/* verilog/stream_reg.sv */
//==========================================================================
// two-entry skid buffer, one cycle latency, one beat per cycle
// input ready comes straight from a flop and drops only when both are full
//==========================================================================
`default_nettype none

module stream_reg #(
  parameter type payload_t = logic
) (
  input  wire      ap_clk,
  input  wire      areset,
  mm_stream_if.snk i_s,
  mm_stream_if.src o_m
);

  // output entry
  logic     out_valid;
  logic     out_last;
  payload_t out_data;
  // skid entry, filled only while the output stalls
  logic     skid_valid;
  logic     skid_last;
  payload_t skid_data;

  logic     in_fire;
  logic     out_open;

  assign in_fire  = i_s.valid & i_s.ready;
  // output entry can take a new beat this edge
  assign out_open = ~out_valid | o_m.ready;

  assign i_s.ready = ~skid_valid;

  assign o_m.valid = out_valid;
  assign o_m.last  = out_last;
  assign o_m.data  = out_data;

  //========================================================================
  // occupancy
  //========================================================================

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_open) begin
      // skid drains first; input is blocked while skid is full
      out_valid  <= skid_valid | in_fire;
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  //========================================================================
  // payload
  //========================================================================

  always_ff @(posedge ap_clk) begin
    if (out_open) begin
      if (skid_valid) begin
        out_data <= skid_data;
        out_last <= skid_last;
      end else if (in_fire) begin
        out_data <= i_s.data;
        out_last <= i_s.last;
      end
    end else if (in_fire) begin
      skid_data <= i_s.data;
      skid_last <= i_s.last;
    end
  end

  // a stalled beat stays put until it is taken
  a_hold_stalled : assert property (@(posedge ap_clk) disable iff (areset)
    (o_m.valid && !o_m.ready) |=> (o_m.valid && $stable(o_m.data) && $stable(o_m.last)));

endmodule : stream_reg

`default_nettype wire

/* mac_array/outer_product_mac.sv */
//==========================================================================
// N x N MAC grid fed in outer-product order, multiply then accumulate
// first pair of a job loads the cells; matrix valid 2 cycles after last pair
//==========================================================================
`default_nettype none

`include "mm_defs.svh"

module outer_product_mac (
  input  wire             ap_clk,
  input  wire             areset,
  mm_stream_if.snk        i_op,
  input  wire             i_drain_free,
  output logic            o_matrix_valid,
  output mm_pkg::matrix_t o_matrix
);

  localparam int N = `MM_DIM;

  logic            op_fire;
  // next accepted pair opens a job
  logic            first_beat;
  // multiply stage
  logic            prod_valid;
  logic            prod_last;
  logic            prod_first;
  mm_pkg::matrix_t prod;
  // accumulate stage
  mm_pkg::matrix_t acc;

  // stall while the drain still holds the previous result
  assign i_op.ready = i_drain_free;
  assign op_fire    = i_op.valid & i_op.ready;

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      first_beat <= 1'b1;
    end else if (op_fire) begin
      first_beat <= i_op.last;
    end
  end

  //========================================================================
  // multiply stage
  //========================================================================

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      prod_valid <= 1'b0;
      prod_last  <= 1'b0;
      prod_first <= 1'b0;
    end else begin
      prod_valid <= op_fire;
      prod_last  <= op_fire & i_op.last;
      prod_first <= op_fire & first_beat;
    end
  end

  // cell [i][j] gets A[i][k] * B[k][j] for beat k
  always_ff @(posedge ap_clk) begin
    if (op_fire) begin
      for (int i = 0; i < N; i++) begin
        for (int j = 0; j < N; j++) begin
          prod[i][j] <= mm_pkg::acc_t'($signed(i_op.data.a_col[i]))
                      * mm_pkg::acc_t'($signed(i_op.data.b_row[j]));
        end
      end
    end
  end

  //========================================================================
  // accumulate stage
  //========================================================================

  // sums wrap at the accumulator width
  always_ff @(posedge ap_clk) begin
    if (prod_valid) begin
      for (int i = 0; i < N; i++) begin
        for (int j = 0; j < N; j++) begin
          acc[i][j] <= prod_first ? prod[i][j] : acc[i][j] + prod[i][j];
        end
      end
    end
  end

  // last leaves the accumulate stage
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      o_matrix_valid <= 1'b0;
    end else begin
      o_matrix_valid <= prod_valid & prod_last;
    end
  end

  assign o_matrix = acc;

endmodule : outer_product_mac

`default_nettype wire

/* mac_array/result_drain.sv */
//==========================================================================
// captures one finished matrix and sends it as MM_DIM rows, row 0 first
// a new matrix may only arrive while free; the row holds under back-pressure
//==========================================================================
`default_nettype none

`include "mm_defs.svh"

module result_drain (
  input  wire             ap_clk,
  input  wire             areset,
  input  wire             i_matrix_valid,
  input  mm_pkg::matrix_t i_matrix,
  output logic            o_free,
  mm_stream_if.src        o_res
);

  localparam int ROW_W = (`MM_DIM > 1) ? $clog2(`MM_DIM) : 1;

  logic             holding;
  logic [ROW_W-1:0] row_idx;
  logic             row_fire;
  logic             last_row;
  mm_pkg::matrix_t  mat;

  assign row_fire = o_res.valid & o_res.ready;
  assign last_row = (row_idx == ROW_W'(`MM_DIM - 1));

  assign o_free = ~holding;

  // current row straight from the held matrix
  assign o_res.valid = holding;
  assign o_res.last  = last_row;
  assign o_res.data  = mat[row_idx];

  //========================================================================
  // row sequencing
  //========================================================================

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      holding <= 1'b0;
      row_idx <= '0;
    end else if (i_matrix_valid) begin
      holding <= 1'b1;
      row_idx <= '0;
    end else if (row_fire) begin
      if (last_row) begin
        // free again once the final row has gone
        holding <= 1'b0;
        row_idx <= '0;
      end else begin
        row_idx <= row_idx + 1'b1;
      end
    end
  end

  // snapshot of the accumulators
  always_ff @(posedge ap_clk) begin
    if (i_matrix_valid) begin
      mat <= i_matrix;
    end
  end

  // the MAC array never hands over a result before the last one drained
  a_no_overrun : assert property (@(posedge ap_clk) disable iff (areset)
    i_matrix_valid |-> o_free);

endmodule : result_drain

`default_nettype wire

/* verilog/matrix_mult_top.sv */
//==========================================================================
// C = A x B for MM_DIM square matrices; beat k is A column k and B row k
// C leaves as MM_DIM rows with last on the final one; done ends the job
//==========================================================================
`default_nettype none

module matrix_mult_top (
  // control
  input  wire            ap_clk,
  input  wire            areset,
  input  wire            i_start,
  output logic           o_idle,
  output logic           o_done,
  // A stream
  input  wire            i_a_valid,
  output logic           o_a_ready,
  input  mm_pkg::vec_t   i_a_data,
  // B stream
  input  wire            i_b_valid,
  output logic           o_b_ready,
  input  mm_pkg::vec_t   i_b_data,
  // C stream
  output logic           o_c_valid,
  input  wire            i_c_ready,
  output mm_pkg::c_row_t o_c_data,
  output logic           o_c_last
);

  logic            busy;
  logic            job_end;
  logic            matrix_valid;
  logic            drain_free;
  mm_pkg::matrix_t matrix;

  // [0] before the skid register, [1] after it
  mm_stream_if #(.payload_t(mm_pkg::operand_t)) op_if  [2] ();
  mm_stream_if #(.payload_t(mm_pkg::c_row_t))   res_if [2] ();

  //========================================================================
  // control
  //========================================================================

  // final row accepted by the consumer
  assign job_end = o_c_valid & i_c_ready & o_c_last;

  mm_ctrl mm_ctrl_inst (
    .ap_clk    (ap_clk),
    .areset    (areset),
    .i_start   (i_start),
    .i_job_end (job_end),
    .o_busy    (busy),
    .o_idle    (o_idle),
    .o_done    (o_done)
  );

  //========================================================================
  // operand path
  //========================================================================

  operand_join operand_join_inst (
    .ap_clk    (ap_clk),
    .areset    (areset),
    .i_busy    (busy),
    .i_a_valid (i_a_valid),
    .o_a_ready (o_a_ready),
    .i_a_data  (i_a_data),
    .i_b_valid (i_b_valid),
    .o_b_ready (o_b_ready),
    .i_b_data  (i_b_data),
    .o_op      (op_if[0])
  );

  stream_reg #(.payload_t(mm_pkg::operand_t)) op_reg_inst (
    .ap_clk (ap_clk),
    .areset (areset),
    .i_s    (op_if[0]),
    .o_m    (op_if[1])
  );

  outer_product_mac outer_product_mac_inst (
    .ap_clk         (ap_clk),
    .areset         (areset),
    .i_op           (op_if[1]),
    .i_drain_free   (drain_free),
    .o_matrix_valid (matrix_valid),
    .o_matrix       (matrix)
  );

  //========================================================================
  // result path
  //========================================================================

  result_drain result_drain_inst (
    .ap_clk         (ap_clk),
    .areset         (areset),
    .i_matrix_valid (matrix_valid),
    .i_matrix       (matrix),
    .o_free         (drain_free),
    .o_res          (res_if[0])
  );

  stream_reg #(.payload_t(mm_pkg::c_row_t)) res_reg_inst (
    .ap_clk (ap_clk),
    .areset (areset),
    .i_s    (res_if[0]),
    .o_m    (res_if[1])
  );

  // C stream out to the pins
  assign o_c_valid       = res_if[1].valid;
  assign o_c_data        = res_if[1].data;
  assign o_c_last        = res_if[1].last;
  assign res_if[1].ready = i_c_ready;

endmodule : matrix_mult_top

`default_nettype wire

/* verification/tb_matrix_mult.sv */
//==========================================================================
// table-driven testbench for matrix_mult_top, one job per table entry
// expected C is a signed reference sum of the generated A and B, 32-bit wrap
//==========================================================================
`default_nettype none

`include "mm_defs.svh"

module tb_matrix_mult;

  localparam int N           = `MM_DIM;
  localparam int NUM_TESTS   = 8;
  // cycle limits of the wait loops
  localparam int FEED_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 200;

  typedef enum int {K_IDENT, K_ZERO, K_RAND, K_EXTREME, K_MIN} kind_e;

  typedef struct {
    string name;
    kind_e kind;
    // random C ready
    bit    bp;
    // random A/B valid gaps
    bit    gaps;
    // start stays high through the job
    bit    hold_start;
    // done pulses the job should give
    int    exp_dones;
  } test_t;

  logic           ap_clk;
  logic           areset;
  logic           i_start;
  logic           o_idle;
  logic           o_done;
  logic           i_a_valid;
  logic           o_a_ready;
  mm_pkg::vec_t   i_a_data;
  logic           i_b_valid;
  logic           o_b_ready;
  mm_pkg::vec_t   i_b_data;
  logic           o_c_valid;
  logic           i_c_ready;
  mm_pkg::c_row_t o_c_data;
  logic           o_c_last;

  test_t          tests [NUM_TESTS];
  mm_pkg::elem_t  mat_a [N][N];
  mm_pkg::elem_t  mat_b [N][N];
  mm_pkg::acc_t   exp_c [N][N];
  logic [31:0]    lfsr;
  int             errors;
  int             checks;
  int             tests_run;
  int             failed_tests;
  int             done_count;
  bit             abort;

  matrix_mult_top matrix_mult_top_inst (
    .ap_clk    (ap_clk),
    .areset    (areset),
    .i_start   (i_start),
    .o_idle    (o_idle),
    .o_done    (o_done),
    .i_a_valid (i_a_valid),
    .o_a_ready (o_a_ready),
    .i_a_data  (i_a_data),
    .i_b_valid (i_b_valid),
    .o_b_ready (o_b_ready),
    .i_b_data  (i_b_data),
    .o_c_valid (o_c_valid),
    .i_c_ready (i_c_ready),
    .o_c_data  (o_c_data),
    .o_c_last  (o_c_last)
  );

  always #2 ap_clk = ~ap_clk;

  // done pulses seen since reset
  always @(posedge ap_clk) begin
    if (areset) begin
      done_count <= 0;
    end else if (o_done) begin
      done_count <= done_count + 1;
    end
  end

  //==========================================================================
  // random source and operand builders
  //==========================================================================

  // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic lfsr_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ 32'h8020_0003;
    return out;
  endfunction

  function automatic logic [15:0] rand_elem();
    logic [15:0] v;
    for (int b = 0; b < 16; b++) v[b] = lfsr_bit();
    return v;
  endfunction

  // beat k carries column k of A
  function automatic mm_pkg::vec_t a_col(input int k);
    mm_pkg::vec_t v;
    for (int i = 0; i < N; i++) v[i] = mat_a[i][k];
    return v;
  endfunction

  // and row k of B
  function automatic mm_pkg::vec_t b_row(input int k);
    mm_pkg::vec_t v;
    for (int j = 0; j < N; j++) v[j] = mat_b[k][j];
    return v;
  endfunction

  task automatic fill_matrices(input kind_e kind);
    longint sum;
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        case (kind)
          K_IDENT:   mat_a[i][j] = (i == j) ? 16'sd1 : 16'sd0;
          K_ZERO:    mat_a[i][j] = '0;
          K_RAND:    mat_a[i][j] = rand_elem();
          K_EXTREME: mat_a[i][j] = lfsr_bit() ? 16'sh8000 : 16'sh7fff;
          default:   mat_a[i][j] = 16'sh8000;
        endcase
        case (kind)
          K_ZERO:    mat_b[i][j] = '0;
          K_EXTREME: mat_b[i][j] = lfsr_bit() ? 16'sh8000 : 16'sh7fff;
          K_MIN:     mat_b[i][j] = 16'sh8000;
          default:   mat_b[i][j] = rand_elem();
        endcase
      end
    end
    // C[i][j] = sum over k of A[i][k] * B[k][j], kept to the low 32 bits
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        sum = 0;
        for (int k = 0; k < N; k++) sum += longint'(mat_a[i][k]) * longint'(mat_b[k][j]);
        exp_c[i][j] = sum[31:0];
      end
    end
  endtask

  //==========================================================================
  // checks and reporting
  //==========================================================================

  task automatic expect_equal(input string sig, input logic [31:0] got,
                              input logic [31:0] expv);
    checks++;
    assert (got === expv)
    else begin
      $display("Fail at %0t: %s expected %h, got %h", $time, sig, expv, got);
      errors++;
    end
  endtask

  task automatic timed_out(input string what);
    $display("timeout at %0t: gave up waiting for %s", $time, what);
    errors++;
    abort = 1'b1;
  endtask

  task automatic report_test(input string name, input int errs);
    tests_run++;
    if (errs != 0) failed_tests++;
    $display("test %-14s %s, %0d errors", name, (errs == 0) ? "passed" : "FAILED", errs);
  endtask

  //==========================================================================
  // stimulus
  //==========================================================================

  // a raised valid holds until its beat is taken
  task automatic drive_operands(input int k, input bit xfer, input bit gaps);
    if (k >= N) begin
      i_a_valid <= 1'b0;
      i_b_valid <= 1'b0;
    end else begin
      if (!i_a_valid || xfer) begin
        i_a_valid <= gaps ? lfsr_bit() : 1'b1;
        i_a_data  <= a_col(k);
      end
      if (!i_b_valid || xfer) begin
        i_b_valid <= gaps ? lfsr_bit() : 1'b1;
        i_b_data  <= b_row(k);
      end
    end
  endtask

  task automatic check_reset();
    expect_equal("o_idle", 32'(o_idle), 32'd1);
    expect_equal("o_done", 32'(o_done), 32'd0);
    expect_equal("o_c_valid", 32'(o_c_valid), 32'd0);
    expect_equal("o_a_ready", 32'(o_a_ready), 32'd0);
    expect_equal("o_b_ready", 32'(o_b_ready), 32'd0);
    // operands offered before any start are left alone
    i_a_valid <= 1'b1;
    i_b_valid <= 1'b1;
    repeat (4) begin
      @(posedge ap_clk);
      expect_equal("o_a_ready", 32'(o_a_ready), 32'd0);
      expect_equal("o_b_ready", 32'(o_b_ready), 32'd0);
    end
    i_a_valid <= 1'b0;
    i_b_valid <= 1'b0;
    @(posedge ap_clk);
  endtask

  task automatic run_job(input int t);
    int k;
    int r;
    int guard;
    bit xfer;
    int dones_before;
    fill_matrices(tests[t].kind);
    dones_before = done_count;
    // start edge is seen one edge later, idle is low after the next one
    i_start <= 1'b1;
    @(posedge ap_clk);
    if (!tests[t].hold_start) i_start <= 1'b0;
    @(posedge ap_clk);
    expect_equal("o_idle", 32'(o_idle), 32'd0);
    k     = 0;
    guard = 0;
    drive_operands(0, 1'b0, tests[t].gaps);
    while (k < N && !abort) begin
      @(posedge ap_clk);
      guard++;
      xfer = i_a_valid && o_a_ready;
      if (xfer) begin
        expect_equal("o_b_ready", 32'(i_b_valid && o_b_ready), 32'd1);
        k++;
      end
      drive_operands(k, xfer, tests[t].gaps);
      if (guard >= FEED_LIMIT && k < N) timed_out("A/B beats to be accepted");
    end
    // collect C rows, row 0 first
    r     = 0;
    guard = 0;
    i_c_ready <= tests[t].bp ? lfsr_bit() : 1'b1;
    while (r < N && !abort) begin
      @(posedge ap_clk);
      guard++;
      if (o_c_valid && i_c_ready) begin
        for (int j = 0; j < N; j++) begin
          expect_equal($sformatf("o_c_data[%0d] of row %0d", j, r), o_c_data[j], exp_c[r][j]);
        end
        expect_equal("o_c_last", 32'(o_c_last), 32'(r == N - 1));
        r++;
      end
      if (r >= N) i_c_ready <= 1'b0;
      else if (tests[t].bp) i_c_ready <= lfsr_bit();
      else i_c_ready <= 1'b1;
      if (guard >= DRAIN_LIMIT && r < N) timed_out("C rows");
    end
    if (abort) return;
    // done in the cycle after the final row, idle back at the same time
    @(posedge ap_clk);
    expect_equal("o_done", 32'(o_done), 32'd1);
    expect_equal("o_idle", 32'(o_idle), 32'd1);
    expect_equal("o_c_valid", 32'(o_c_valid), 32'd0);
    @(posedge ap_clk);
    expect_equal("o_done", 32'(o_done), 32'd0);
    // a start still held high must not restart the kernel
    repeat (3) begin
      @(posedge ap_clk);
      expect_equal("o_idle", 32'(o_idle), 32'd1);
    end
    i_start <= 1'b0;
    @(posedge ap_clk);
    expect_equal("done pulse count", done_count - dones_before, tests[t].exp_dones);
  endtask

  task automatic load_table();
    tests[0] = '{"identity",     K_IDENT,   1'b0, 1'b0, 1'b0, 1};
    tests[1] = '{"all_zero",     K_ZERO,    1'b0, 1'b0, 1'b0, 1};
    tests[2] = '{"random",       K_RAND,    1'b0, 1'b0, 1'b0, 1};
    tests[3] = '{"extremes",     K_EXTREME, 1'b0, 1'b0, 1'b0, 1};
    tests[4] = '{"all_min_wrap", K_MIN,     1'b0, 1'b1, 1'b0, 1};
    tests[5] = '{"backpressure", K_RAND,    1'b1, 1'b1, 1'b0, 1};
    tests[6] = '{"start_held",   K_RAND,    1'b1, 1'b0, 1'b1, 1};
    tests[7] = '{"back_to_back", K_RAND,    1'b1, 1'b1, 1'b0, 1};
  endtask

  initial begin
    int errs_before;
    ap_clk       = 1'b0;
    areset       = 1'b1;
    i_start      = 1'b0;
    i_a_valid    = 1'b0;
    i_a_data     = '0;
    i_b_valid    = 1'b0;
    i_b_data     = '0;
    i_c_ready    = 1'b0;
    lfsr         = 32'h7fd9_73cf;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    failed_tests = 0;
    abort        = 1'b0;
    load_table();
    repeat (2) @(posedge ap_clk);
    areset <= 1'b0;
    @(posedge ap_clk);
    errs_before = errors;
    check_reset();
    report_test("reset", errors - errs_before);
    for (int t = 0; t < NUM_TESTS && !abort; t++) begin
      errs_before = errors;
      run_job(t);
      report_test(tests[t].name, errors - errs_before);
    end
    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : tb_matrix_mult

`default_nettype wire

/* matrix_mult_top.f */
+incdir+common
common/mm_pkg.sv
common/mm_stream_if.sv
verilog/mm_ctrl.sv
verilog/operand_join.sv
verilog/stream_reg.sv
mac_array/outer_product_mac.sv
mac_array/result_drain.sv
verilog/matrix_mult_top.sv
verification/tb_matrix_mult.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile the matrix multiplier testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f matrix_mult_top.f \
  --top-module tb_matrix_mult \
  -Mdir obj_dir \
  -o tb_matrix_mult

status=0
sim_out=$(./obj_dir/tb_matrix_mult) || status=$?
printf '%s\n' "$sim_out"

if [ "$status" -eq 0 ] && grep -qx "Finished with no errors" <<< "$sim_out"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
